// File: all.f
+incdir+tests
hw/mm_map_pkg.sv
hw/mm_bus_pkg.sv
hw/mm_addr_decode.sv
hw/mm_dp_ram.sv
hw/mm_ctrl_regs.sv
hw/mm_data_resp.sv
hw/mm_ram_top.sv
tests/tb_mm_ram.sv

// File: Bender.yml
package:
  name: mm_ram

sources:
  - files:
      - hw/mm_map_pkg.sv
      - hw/mm_bus_pkg.sv
      - hw/mm_addr_decode.sv
      - hw/mm_dp_ram.sv
      - hw/mm_ctrl_regs.sv
      - hw/mm_data_resp.sv
      - hw/mm_ram_top.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/tb_mm_ram.sv

// File: tests/tb_mm_model.svh
`ifndef TB_MM_MODEL_SVH
`define TB_MM_MODEL_SVH

// status values and timer interrupt id of the memory map
localparam logic [31:0] RefPass  = 32'd123456789;
localparam logic [31:0] RefFail  = 32'd1;
localparam logic [4:0]  RefIrqId = 5'd7;

// expected RAM contents, one entry per byte
logic [7:0]  ref_mem [2 ** AddrWidth];
logic [31:0] ref_cnt;
logic [31:0] ref_mask;
logic        ref_irq;
logic [31:0] ref_exit_value;

function automatic void ref_reset();
  ref_cnt        = '0;
  ref_mask       = '0;
  ref_irq        = 1'b0;
  ref_exit_value = '0;
endfunction

function automatic target_e ref_target(input logic [31:0] addr);
  if (addr < 32'(2 ** AddrWidth)) return tgt_ram;
  if (addr == StatusAddr || addr == ExitAddr || addr == TimerMaskAddr ||
      addr == TimerCntAddr || addr == TimerReadAddr) return tgt_ctrl;
  return tgt_err;
endfunction

function automatic logic [31:0] ref_read_word(input logic [31:0] addr);
  logic [31:0] word;
  for (int i = 0; i < 4; i++) begin
    word[8*i +: 8] = ref_mem[{addr[AddrWidth-1:2], 2'(i)}];
  end
  return word;
endfunction

// one clock edge of data port and timer, reads see the state before the edge
function automatic void ref_edge(
  input  logic       req,
  input  data_req_t  s,
  input  logic       ack,
  input  logic [4:0] id,
  output data_resp_t exp,
  output logic       pass,
  output logic       fail,
  output logic       exit_pulse
);
  target_e tgt;
  logic    wr;
  logic    ctrl_wr;
  logic    tick;
  tgt     = ref_target(s.addr);
  wr      = req && s.we;
  ctrl_wr = wr && (tgt == tgt_ctrl);
  exp     = '{rvalid: req, err: 1'b0, rdata: 32'd0};
  if (req && !s.we) begin
    if (tgt == tgt_ram) exp.rdata = ref_read_word(s.addr);
    else if (tgt == tgt_err) exp.err = 1'b1;
    else if (s.addr == TimerReadAddr) exp.rdata = ref_cnt;
  end
  pass       = ctrl_wr && (s.addr == StatusAddr) && (s.wdata == RefPass);
  fail       = ctrl_wr && (s.addr == StatusAddr) && (s.wdata == RefFail);
  exit_pulse = ctrl_wr && (s.addr == ExitAddr);
  // the count pauses while a timer register is written
  tick = !(ctrl_wr && (s.addr == TimerMaskAddr || s.addr == TimerCntAddr)) && (ref_cnt != 0);
  if (ack && (id == RefIrqId)) ref_irq = 1'b0;
  else if (tick && (ref_cnt == 32'd1) && ref_mask[RefIrqId]) ref_irq = 1'b1;
  if (ctrl_wr && (s.addr == TimerCntAddr)) ref_cnt = s.wdata;
  else if (tick) ref_cnt = ref_cnt - 32'd1;
  if (ctrl_wr && (s.addr == TimerMaskAddr)) ref_mask = s.wdata;
  if (exit_pulse) ref_exit_value = s.wdata;
  if (wr && (tgt == tgt_ram)) begin
    for (int i = 0; i < 4; i++) begin
      if (s.be[i]) ref_mem[{s.addr[AddrWidth-1:2], 2'(i)}] = s.wdata[8*i +: 8];
    end
  end
endfunction

`endif

// File: tests/tb_mm_ram.sv
`timescale 1ns/100ps

module tb_mm_ram
  import mm_bus_pkg::*;
  import mm_map_pkg::*;
();

  localparam int unsigned AddrWidth    = 12;
  localparam int unsigned RamWords     = 2 ** (AddrWidth - 2);
  localparam int unsigned NumRandOps   = 300;
  localparam int unsigned MaxTimerLoad = 40;
  // fill, four random phases, two timer runs and the short directed checks
  localparam int unsigned TotalCycles  = RamWords + 4 * NumRandOps + 2 * (MaxTimerLoad + 12) + 40;

  logic        clk;
  logic        rst_n;
  logic        instr_req;
  logic [31:0] instr_addr;
  logic        instr_gnt;
  instr_resp_t instr_resp;
  logic        data_req;
  data_req_t   data_req_s;
  logic        data_gnt;
  data_resp_t  data_resp;
  logic        irq_ack;
  logic [4:0]  irq_id;
  logic        irq_timer;
  logic        tests_passed;
  logic        tests_failed;
  logic        exit_valid;
  logic [31:0] exit_value;
  int unsigned error_count;
  int unsigned cycle_count;

  `include "tb_mm_model.svh"

  mm_ram_top #(
    .AddrWidth (AddrWidth)
  ) dut_i (
    .clk_i          (clk),
    .rst_ni         (rst_n),
    .instr_req_i    (instr_req),
    .instr_addr_i   (instr_addr),
    .instr_gnt_o    (instr_gnt),
    .instr_resp_o   (instr_resp),
    .data_req_i     (data_req),
    .data_req_s_i   (data_req_s),
    .data_gnt_o     (data_gnt),
    .data_resp_o    (data_resp),
    .irq_ack_i      (irq_ack),
    .irq_id_i       (irq_id),
    .irq_timer_o    (irq_timer),
    .tests_passed_o (tests_passed),
    .tests_failed_o (tests_failed),
    .exit_valid_o   (exit_valid),
    .exit_value_o   (exit_value)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #10 clk = ~clk;
    end
  end

  initial begin
    #(TotalCycles * 20 + 2000);
    $display("run did not finish in time, stopping after %0d cycles", cycle_count);
    $display("Some tests failed");
    $finish;
  end

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    error_count++;
    $display("[ERROR] %0d ns: %s is %08h, expected %08h", $time, name, got, exp);
  endtask

  task automatic report_failure(input string what);
    error_count++;
    $display("[ERROR] %0d ns: %s", $time, what);
  endtask

  // one clock cycle with the inputs the caller set at the falling edge
  task automatic step();
    data_resp_t  exp_data;
    logic [31:0] exp_instr;
    logic        exp_ivalid;
    logic        exp_pass;
    logic        exp_fail;
    logic        exp_exit;
    @(posedge clk);
    if (instr_gnt !== instr_req) report_mismatch("instr_gnt_o", instr_gnt, instr_req);
    if (data_gnt !== data_req) report_mismatch("data_gnt_o", data_gnt, data_req);
    exp_ivalid = instr_req;
    exp_instr  = ref_read_word(instr_addr);
    ref_edge(data_req, data_req_s, irq_ack, irq_id, exp_data, exp_pass, exp_fail, exp_exit);
    @(negedge clk);
    cycle_count++;
    if (instr_resp.rvalid !== exp_ivalid)
      report_mismatch("instr_resp_o.rvalid", instr_resp.rvalid, exp_ivalid);
    if (exp_ivalid && (instr_resp.rdata !== exp_instr))
      report_mismatch("instr_resp_o.rdata", instr_resp.rdata, exp_instr);
    if (data_resp.rvalid !== exp_data.rvalid)
      report_mismatch("data_resp_o.rvalid", data_resp.rvalid, exp_data.rvalid);
    if (data_resp.err !== exp_data.err)
      report_mismatch("data_resp_o.err", data_resp.err, exp_data.err);
    if (data_resp.rdata !== exp_data.rdata)
      report_mismatch("data_resp_o.rdata", data_resp.rdata, exp_data.rdata);
    if (irq_timer !== ref_irq) report_mismatch("irq_timer_o", irq_timer, ref_irq);
    if (tests_passed !== exp_pass) report_mismatch("tests_passed_o", tests_passed, exp_pass);
    if (tests_failed !== exp_fail) report_mismatch("tests_failed_o", tests_failed, exp_fail);
    if (exit_valid !== exp_exit) report_mismatch("exit_valid_o", exit_valid, exp_exit);
    if (exit_value !== ref_exit_value)
      report_mismatch("exit_value_o", exit_value, ref_exit_value);
    instr_req = 1'b0;
    data_req  = 1'b0;
    irq_ack   = 1'b0;
    irq_id    = 5'd0;
  endtask

  task automatic data_write(input logic [31:0] addr, input logic [3:0] be,
                            input logic [31:0] wdata);
    data_req   = 1'b1;
    data_req_s = '{addr: addr, we: 1'b1, be: be, wdata: wdata};
    step();
  endtask

  task automatic data_read(input logic [31:0] addr);
    data_req   = 1'b1;
    data_req_s = '{addr: addr, we: 1'b0, be: 4'hf, wdata: 32'd0};
    step();
  endtask

  function automatic logic [31:0] random_word_addr();
    return 32'($urandom_range(0, RamWords - 1)) << 2;
  endfunction

  // load a random count and watch for the interrupt
  task automatic timer_run(input logic mask_on);
    logic [31:0] n;
    int unsigned steps;
    logic        seen_irq;
    n = 32'($urandom_range(3, MaxTimerLoad));
    data_write(TimerMaskAddr, 4'hf, mask_on ? (32'd1 << RefIrqId) : 32'd0);
    data_write(TimerCntAddr, 4'hf, n);
    steps    = 1;
    seen_irq = irq_timer;
    while (!seen_irq && (steps < n + 4)) begin
      // poll the count view every other cycle
      if (steps % 2 == 0) data_read(TimerReadAddr);
      else step();
      steps++;
      seen_irq = irq_timer;
    end
    if (mask_on && (!seen_irq || (steps != n + 1)))
      report_failure($sformatf("timer interrupt after %0d cycles, expected %0d", steps, n + 1));
    if (!mask_on && seen_irq) report_failure("timer interrupt rose with the mask bit clear");
  endtask

  initial begin
    int unsigned seed;
    logic [31:0] addr;
    seed        = $urandom(13085);
    error_count = 0;
    cycle_count = 0;
    rst_n       = 1'b0;
    instr_req   = 1'b0;
    instr_addr  = '0;
    data_req    = 1'b0;
    data_req_s  = '0;
    irq_ack     = 1'b0;
    irq_id      = 5'd0;
    ref_reset();
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    if ({irq_timer, tests_passed, tests_failed, exit_valid, data_resp.rvalid,
         data_resp.err, instr_resp.rvalid} !== 7'b0)
      report_failure("outputs not low after reset");

    // fill every word so that later partial writes start from known bytes
    for (int w = 0; w < RamWords; w++) begin
      addr = 32'(w) << 2;
      data_write(addr, 4'hf, {~addr[15:0], addr[15:0]} ^ 32'h3c5a_96e1);
    end
    for (int i = 0; i < NumRandOps; i++) begin
      addr = random_word_addr();
      data_write(addr, 4'($urandom), $urandom);
      data_read(addr);
    end
    for (int i = 0; i < NumRandOps; i++) begin
      data_read(random_word_addr());
    end

    // fetches mixed with data traffic in the same cycles
    for (int i = 0; i < NumRandOps; i++) begin
      instr_req  = 1'($urandom);
      instr_addr = random_word_addr();
      data_req   = 1'($urandom);
      data_req_s = '{addr: random_word_addr(), we: 1'($urandom), be: 4'($urandom),
                     wdata: $urandom};
      step();
    end

    data_write(StatusAddr, 4'hf, RefPass);
    step();
    data_write(StatusAddr, 4'hf, RefFail);
    step();
    data_write(StatusAddr, 4'hf, $urandom | 32'h8000_0000);
    data_write(ExitAddr, 4'hf, $urandom);
    step();

    timer_run(1'b1);
    irq_ack = 1'b1;
    irq_id  = 5'd3;
    step();
    irq_ack = 1'b1;
    irq_id  = RefIrqId;
    step();
    if (irq_timer !== 1'b0) report_failure("timer interrupt still high after the acknowledge");
    timer_run(1'b0);

    // unmapped reads and control reads without data
    data_read(32'h0000_2000);
    data_read($urandom | 32'h8000_0000);
    data_read(32'h1500_0008);
    data_read(StatusAddr);
    step();

    $display("cycles run: %0d, errors: %0d", cycle_count, error_count);
    if (error_count == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// File: hw/mm_ram_top.sv
`timescale 1ns/100ps

module mm_ram_top
  import mm_bus_pkg::*;
#(
  parameter int unsigned AddrWidth = 16
) (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        instr_req_i,
  input  logic [31:0] instr_addr_i,
  output logic        instr_gnt_o,
  output instr_resp_t instr_resp_o,
  input  logic        data_req_i,
  input  data_req_t   data_req_s_i,
  output logic        data_gnt_o,
  output data_resp_t  data_resp_o,
  input  logic        irq_ack_i,
  input  logic [4:0]  irq_id_i,
  output logic        irq_timer_o,
  output logic        tests_passed_o,
  output logic        tests_failed_o,
  output logic        exit_valid_o,
  output logic [31:0] exit_value_o
);

  logic        ram_req;
  logic        ctrl_req;
  target_e     target;
  logic [31:0] ram_rdata;
  logic [31:0] ctrl_rdata;

  // no target ever stalls, so every request is granted at once
  assign instr_gnt_o = instr_req_i;
  assign data_gnt_o  = data_req_i;

  mm_addr_decode #(
    .AddrWidth (AddrWidth)
  ) u_decode (
    .data_req_i   (data_req_i),
    .data_req_s_i (data_req_s_i),
    .ram_req_o    (ram_req),
    .ctrl_req_o   (ctrl_req),
    .target_o     (target)
  );

  mm_dp_ram #(
    .AddrWidth (AddrWidth)
  ) u_ram (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .instr_req_i    (instr_req_i),
    .instr_addr_i   (instr_addr_i),
    .instr_rdata_o  (instr_resp_o.rdata),
    .instr_rvalid_o (instr_resp_o.rvalid),
    .data_req_i     (ram_req),
    .data_req_s_i   (data_req_s_i),
    .data_rdata_o   (ram_rdata)
  );

  mm_ctrl_regs u_ctrl (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .ctrl_req_i     (ctrl_req),
    .data_req_s_i   (data_req_s_i),
    .irq_ack_i      (irq_ack_i),
    .irq_id_i       (irq_id_i),
    .ctrl_rdata_o   (ctrl_rdata),
    .irq_timer_o    (irq_timer_o),
    .tests_passed_o (tests_passed_o),
    .tests_failed_o (tests_failed_o),
    .exit_valid_o   (exit_valid_o),
    .exit_value_o   (exit_value_o)
  );

  mm_data_resp u_resp (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .data_req_i   (data_req_i),
    .target_i     (target),
    .ram_rdata_i  (ram_rdata),
    .ctrl_rdata_i (ctrl_rdata),
    .data_resp_o  (data_resp_o)
  );

endmodule

// File: hw/mm_data_resp.sv
`timescale 1ns/100ps

module mm_data_resp
  import mm_bus_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        data_req_i,
  input  target_e     target_i,
  input  logic [31:0] ram_rdata_i,
  input  logic [31:0] ctrl_rdata_i,
  output data_resp_t  data_resp_o
);

  logic    rvalid_q;
  target_e target_q;

  // remember where the granted request went
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q <= 1'b0;
      target_q <= tgt_ram;
    end else begin
      rvalid_q <= data_req_i;
      if (data_req_i) begin
        target_q <= target_i;
      end
    end
  end

  // RAM and control block already answer stores with zero
  always_comb begin
    data_resp_o.rvalid = rvalid_q;
    data_resp_o.err    = 1'b0;
    data_resp_o.rdata  = '0;
    if (rvalid_q) begin
      unique case (target_q)
        tgt_ram: begin
          data_resp_o.rdata = ram_rdata_i;
        end
        tgt_ctrl: begin
          data_resp_o.rdata = ctrl_rdata_i;
        end
        default: begin
          data_resp_o.err = 1'b1;
        end
      endcase
    end
  end

  rvalid_after_req_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    data_resp_o.rvalid |-> $past(data_req_i))
    else $error("data rvalid without a request in the previous cycle");

endmodule

// File: hw/mm_ctrl_regs.sv
`timescale 1ns/100ps

module mm_ctrl_regs
  import mm_bus_pkg::*;
  import mm_map_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        ctrl_req_i,
  input  data_req_t   data_req_s_i,
  input  logic        irq_ack_i,
  input  logic [4:0]  irq_id_i,
  output logic [31:0] ctrl_rdata_o,
  output logic        irq_timer_o,
  output logic        tests_passed_o,
  output logic        tests_failed_o,
  output logic        exit_valid_o,
  output logic [31:0] exit_value_o
);

  logic        wr;
  logic        status_wr;
  logic        exit_wr;
  logic        mask_wr;
  logic        cnt_wr;
  logic        cnt_rd;
  logic [31:0] mask_q;
  logic [31:0] timer_cnt;
  logic [31:0] ctrl_rdata_q;
  logic        passed_q;
  logic        failed_q;
  logic        exit_valid_q;
  logic [31:0] exit_value_q;

  assign wr        = ctrl_req_i && data_req_s_i.we;
  assign status_wr = wr && (data_req_s_i.addr == StatusAddr);
  assign exit_wr   = wr && (data_req_s_i.addr == ExitAddr);
  assign mask_wr   = wr && (data_req_s_i.addr == TimerMaskAddr);
  assign cnt_wr    = wr && (data_req_s_i.addr == TimerCntAddr);
  assign cnt_rd    = ctrl_req_i && !data_req_s_i.we && (data_req_s_i.addr == TimerReadAddr);

  // status and exit are pulses one cycle after the store
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      passed_q     <= 1'b0;
      failed_q     <= 1'b0;
      exit_valid_q <= 1'b0;
      exit_value_q <= '0;
      mask_q       <= '0;
    end else begin
      passed_q     <= status_wr && (data_req_s_i.wdata == PassMagic);
      failed_q     <= status_wr && (data_req_s_i.wdata == FailMagic);
      exit_valid_q <= exit_wr;
      if (exit_wr) begin
        exit_value_q <= data_req_s_i.wdata;
      end
      if (mask_wr) begin
        mask_q <= data_req_s_i.wdata;
      end
    end
  end

  // only the count view returns data, other reads give zero
  always_ff @(posedge clk_i) begin
    ctrl_rdata_q <= cnt_rd ? timer_cnt : 32'd0;
  end

  mm_timer u_timer (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .hold_i    (mask_wr || cnt_wr),
    .load_i    (cnt_wr),
    .wdata_i   (data_req_s_i.wdata),
    .irq_en_i  (mask_q[TimerIrqId]),
    .irq_ack_i (irq_ack_i),
    .irq_id_i  (irq_id_i),
    .cnt_o     (timer_cnt),
    .irq_o     (irq_timer_o)
  );

  assign ctrl_rdata_o   = ctrl_rdata_q;
  assign tests_passed_o = passed_q;
  assign tests_failed_o = failed_q;
  assign exit_valid_o   = exit_valid_q;
  assign exit_value_o   = exit_value_q;

  irq_masked_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(irq_timer_o) |-> mask_q[TimerIrqId])
    else $error("timer interrupt raised with mask bit clear");

endmodule

// countdown timer, steered by the register block above
module mm_timer
  import mm_map_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        hold_i,
  input  logic        load_i,
  input  logic [31:0] wdata_i,
  input  logic        irq_en_i,
  input  logic        irq_ack_i,
  input  logic [4:0]  irq_id_i,
  output logic [31:0] cnt_o,
  output logic        irq_o
);

  logic [31:0] cnt_q;
  logic        irq_q;
  logic        tick;

  // no counting in a cycle that writes a timer register
  assign tick = !hold_i && (cnt_q != 32'd0);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
      irq_q <= 1'b0;
    end else begin
      if (load_i) begin
        cnt_q <= wdata_i;
      end else if (tick) begin
        cnt_q <= cnt_q - 32'd1;
      end
      // acknowledge wins over a new expiry
      if (irq_ack_i && (irq_id_i == TimerIrqId)) begin
        irq_q <= 1'b0;
      end else if (tick && (cnt_q == 32'd1) && irq_en_i) begin
        irq_q <= 1'b1;
      end
    end
  end

  assign cnt_o = cnt_q;
  assign irq_o = irq_q;

endmodule

// File: hw/mm_dp_ram.sv
`timescale 1ns/100ps

module mm_dp_ram
  import mm_bus_pkg::*;
#(
  parameter int unsigned AddrWidth = 16
) (
  input  logic        clk_i,
  input  logic        rst_ni,
  // port A, instruction fetch
  input  logic        instr_req_i,
  input  logic [31:0] instr_addr_i,
  output logic [31:0] instr_rdata_o,
  output logic        instr_rvalid_o,
  // port B, data loads and stores
  input  logic        data_req_i,
  input  data_req_t   data_req_s_i,
  output logic [31:0] data_rdata_o
);

  localparam int unsigned Depth = 2 ** AddrWidth;

  logic [7:0] mem_q [Depth];

  logic [AddrWidth-3:0] a_word;
  logic [AddrWidth-3:0] b_word;
  logic [31:0]          instr_rdata_q;
  logic [31:0]          data_rdata_q;
  logic                 instr_rvalid_q;

  // both ports work on aligned words, the low address bits are ignored
  assign a_word = instr_addr_i[AddrWidth-1:2];
  assign b_word = data_req_s_i.addr[AddrWidth-1:2];

  // port B store, one lane per byte enable
  always_ff @(posedge clk_i) begin
    if (data_req_i && data_req_s_i.we) begin
      for (int i = 0; i < 4; i++) begin
        if (data_req_s_i.be[i]) begin
          mem_q[{b_word, 2'(i)}] <= data_req_s_i.wdata[8*i +: 8];
        end
      end
    end
  end

  // port B load, a store answers with zero
  always_ff @(posedge clk_i) begin
    if (data_req_i) begin
      for (int i = 0; i < 4; i++) begin
        data_rdata_q[8*i +: 8] <= data_req_s_i.we ? 8'h00 : mem_q[{b_word, 2'(i)}];
      end
    end
  end

  // port A load, sees the old word when port B writes the same address
  always_ff @(posedge clk_i) begin
    if (instr_req_i) begin
      for (int i = 0; i < 4; i++) begin
        instr_rdata_q[8*i +: 8] <= mem_q[{a_word, 2'(i)}];
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      instr_rvalid_q <= 1'b0;
    end else begin
      instr_rvalid_q <= instr_req_i;
    end
  end

  assign instr_rdata_o  = instr_rdata_q;
  assign instr_rvalid_o = instr_rvalid_q;
  assign data_rdata_o   = data_rdata_q;

endmodule

// File: hw/mm_addr_decode.sv
`timescale 1ns/100ps

module mm_addr_decode
  import mm_bus_pkg::*;
  import mm_map_pkg::*;
#(
  parameter int unsigned AddrWidth = 16
) (
  input  logic      data_req_i,
  input  data_req_t data_req_s_i,
  output logic      ram_req_o,
  output logic      ctrl_req_o,
  output target_e   target_o
);

  logic in_ram;
  logic in_ctrl;

  // everything below 2**AddrWidth is RAM
  assign in_ram = (data_req_s_i.addr >> AddrWidth) == 32'd0;

  // the control block answers on exactly five word addresses
  assign in_ctrl = data_req_s_i.addr inside {
    StatusAddr,
    ExitAddr,
    TimerMaskAddr,
    TimerCntAddr,
    TimerReadAddr
  };

  always_comb begin
    if (in_ram) begin
      target_o = tgt_ram;
    end else if (in_ctrl) begin
      target_o = tgt_ctrl;
    end else begin
      target_o = tgt_err;
    end
  end

  // only one strobe is raised per request
  assign ram_req_o  = data_req_i && (target_o == tgt_ram);
  assign ctrl_req_o = data_req_i && (target_o == tgt_ctrl);

  // stores must always land somewhere, only loads may miss the map
  write_mapped_a : assert final (!(data_req_i && data_req_s_i.we) || target_o != tgt_err)
    else $error("write to unmapped address %08x", data_req_s_i.addr);

endmodule

// File: hw/mm_bus_pkg.sv
package mm_bus_pkg;

  // data port request, the strobe data_req travels beside it
  typedef struct packed {
    logic [31:0] addr;
    // high for a store
    logic        we;
    // byte lanes of a store
    logic [3:0]  be;
    logic [31:0] wdata;
  } data_req_t;

  // instruction port response, one cycle after the grant
  typedef struct packed {
    logic        rvalid;
    logic [31:0] rdata;
  } instr_resp_t;

  // data port response, one cycle after the grant
  typedef struct packed {
    logic        rvalid;
    // set for a read of an unmapped address
    logic        err;
    // zero for stores and error reads
    logic [31:0] rdata;
  } data_resp_t;

  // where a data request ends up
  typedef enum logic [1:0] {
    tgt_ram,
    tgt_ctrl,
    tgt_err
  } target_e;

endpackage

// File: hw/mm_map_pkg.sv
package mm_map_pkg;

  // addresses of the pseudo peripherals above the RAM

  // test status, written by the program when it is done
  parameter logic [31:0] StatusAddr = 32'h2000_0000;

  // exit code, reported together with a one cycle valid
  parameter logic [31:0] ExitAddr = 32'h2000_0004;

  // timer interrupt mask, bit TimerIrqId enables the timer line
  parameter logic [31:0] TimerMaskAddr = 32'h1500_0000;

  // timer count, a write loads the countdown value
  parameter logic [31:0] TimerCntAddr = 32'h1500_0004;

  // read-only view of the current count
  parameter logic [31:0] TimerReadAddr = 32'h1500_1000;

  // values written to the status register

  // signals a passing program
  parameter logic [31:0] PassMagic = 32'd123456789;

  // signals a failing program
  parameter logic [31:0] FailMagic = 32'd1;

  // interrupt lines

  // id of the timer interrupt, as the core reports it with irq_ack
  parameter logic [4:0] TimerIrqId = 5'd7;

endpackage
